// File: hdl/cam_pkg.sv
`default_nettype none

package cam_pkg;

    // ========================================
    // Widths and line geometry
    // ========================================
    localparam int PIX_W      = 16;
    localparam int LINE_LEN   = 64;                    // Pairs per output line.
    localparam int FIFO_DEPTH = 128;                   // Two lines per camera.
    localparam int ADDR_W     = $clog2(FIFO_DEPTH);

    typedef logic [PIX_W-1:0]              pixel_t;
    typedef logic [ADDR_W:0]               level_t;    // Fill level, also pointer width.
    typedef logic [$clog2(LINE_LEN+1)-1:0] cnt_t;

    // Both FIFOs must hold this much before a line starts.
    localparam level_t START_LEVEL = level_t'(16);

    // ========================================
    // Output pair and reader state
    // ========================================
    typedef struct packed {
        pixel_t pix_a;
        pixel_t pix_b;
        logic   sol;                                   // First pair of a line.
        logic   eol;                                   // Last pair of a line.
    } pixel_pair_t;

    typedef enum logic {
        RD_IDLE,
        RD_LINE
    } rd_state_t;

endpackage : cam_pkg

`default_nettype wire

// File: hdl/async_fifo.sv
`default_nettype none

module async_fifo (
    input  wire                  wr_clk,
    input  wire                  wr_rstn,
    input  wire                  wr_en,
    input  wire cam_pkg::pixel_t wr_data,
    output logic                 wr_full,
    output logic                 wr_overflow,
    input  wire                  rd_clk,
    input  wire                  rd_rstn,
    input  wire                  rd_en,
    output cam_pkg::pixel_t      rd_data,
    output logic                 rd_empty,
    output cam_pkg::level_t      rd_level
);
    import cam_pkg::*;

    pixel_t mem [FIFO_DEPTH];

    level_t wr_bin, wr_gray, wr_bin_next;
    level_t rd_bin, rd_gray, rd_bin_next;
    level_t rq1_gray, rq2_gray;                        // Read pointer seen by writer.
    level_t wq1_gray, wq2_gray;                        // Write pointer seen by reader.
    level_t wq2_bin;
    logic   wr_push;
    logic   rd_pop;

    function automatic level_t gray2bin(input level_t g);
        level_t b;
        b[ADDR_W] = g[ADDR_W];
        for (int i = ADDR_W - 1; i >= 0; i--) begin
            b[i] = b[i + 1] ^ g[i];
        end
        return b;
    endfunction

    // ========================================
    // Write domain
    // ========================================
    // Full when the top two gray bits differ and the rest match.
    assign wr_full     = (wr_gray == {~rq2_gray[ADDR_W:ADDR_W-1], rq2_gray[ADDR_W-2:0]});
    assign wr_push     = wr_en && !wr_full;
    assign wr_bin_next = wr_bin + level_t'(1);

    always_ff @(posedge wr_clk or negedge wr_rstn) begin
        if (!wr_rstn) begin
            wr_bin      <= '0;
            wr_gray     <= '0;
            wr_overflow <= 1'b0;
        end else begin
            if (wr_push) begin
                wr_bin  <= wr_bin_next;
                wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
            end
            if (wr_en && wr_full) begin
                wr_overflow <= 1'b1;                   // Sticky until reset.
            end
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_push) begin
            mem[wr_bin[ADDR_W-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk or negedge wr_rstn) begin
        if (!wr_rstn) begin
            rq1_gray <= '0;
            rq2_gray <= '0;
        end else begin
            rq1_gray <= rd_gray;
            rq2_gray <= rq1_gray;
        end
    end

    // ========================================
    // Read domain
    // ========================================
    always_ff @(posedge rd_clk or negedge rd_rstn) begin
        if (!rd_rstn) begin
            wq1_gray <= '0;
            wq2_gray <= '0;
        end else begin
            wq1_gray <= wr_gray;
            wq2_gray <= wq1_gray;
        end
    end

    assign wq2_bin     = gray2bin(wq2_gray);
    assign rd_level    = wq2_bin - rd_bin;
    assign rd_empty    = (rd_gray == wq2_gray);
    assign rd_pop      = rd_en && !rd_empty;           // Pop on empty is ignored.
    assign rd_bin_next = rd_bin + level_t'(1);

    // Show-ahead head word.
    assign rd_data = mem[rd_bin[ADDR_W-1:0]];

    always_ff @(posedge rd_clk or negedge rd_rstn) begin
        if (!rd_rstn) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else if (rd_pop) begin
            rd_bin  <= rd_bin_next;
            rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
        end
    end

endmodule : async_fifo

`default_nettype wire

// File: hdl/pixel_counter.sv
`default_nettype none

module pixel_counter (
    input  wire  rclk,
    input  wire  rstn,
    input  wire  start,
    input  wire  step,
    output logic first,
    output logic last
);
    import cam_pkg::*;

    cnt_t remaining;                                   // Pairs left in the line.

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            remaining <= '0;
        end else if (start) begin
            remaining <= cnt_t'(LINE_LEN);
        end else if (step && remaining != '0) begin
            remaining <= remaining - cnt_t'(1);
        end
    end

    // Nothing popped yet in this line.
    assign first = (remaining == cnt_t'(LINE_LEN));
    assign last  = (remaining == cnt_t'(1));           // Next pop closes the line.

endmodule : pixel_counter

`default_nettype wire

// File: hdl/line_read_fsm.sv
`default_nettype none

module line_read_fsm (
    input  wire                  rclk,
    input  wire                  rstn,
    input  wire cam_pkg::level_t level_a,
    input  wire cam_pkg::level_t level_b,
    input  wire                  empty_a,
    input  wire                  empty_b,
    input  wire                  can_accept,
    input  wire                  last,
    output logic                 start,
    output logic                 pop
);
    import cam_pkg::*;

    rd_state_t state;
    rd_state_t state_next;
    logic      levels_ok;

    // Both cameras far enough ahead to start a line.
    assign levels_ok = (level_a >= START_LEVEL) && (level_b >= START_LEVEL);

    // ========================================
    // Next state and outputs
    // ========================================
    always_comb begin
        state_next = state;
        start      = 1'b0;
        pop        = 1'b0;
        case (state)
            RD_IDLE: begin
                if (levels_ok) begin
                    start      = 1'b1;                 // Loads the pair counter.
                    state_next = RD_LINE;
                end
            end
            RD_LINE: begin
                // One pop feeds both FIFOs so the streams stay aligned.
                pop = !empty_a && !empty_b && can_accept;
                if (pop && last) begin
                    state_next = RD_IDLE;
                end
            end
            default: begin
                state_next = RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state <= RD_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule : line_read_fsm

`default_nettype wire

// File: hdl/pair_out_reg.sv
`default_nettype none

module pair_out_reg (
    input  wire                       rclk,
    input  wire                       rstn,
    input  wire                       load,
    input  wire cam_pkg::pixel_pair_t in_pair,
    output logic                      can_accept,
    output logic                      out_valid,
    input  wire                       out_ready,
    output cam_pkg::pixel_pair_t      out_pair
);

    // Free slot, or the held pair leaves on this edge.
    assign can_accept = !out_valid || out_ready;

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;                         // Drained, nothing new.
        end
    end

    // Held while stalled since load needs can_accept.
    always_ff @(posedge rclk) begin
        if (load) begin
            out_pair <= in_pair;
        end
    end

endmodule : pair_out_reg

`default_nettype wire

// File: hdl/pixel_combine.sv
`default_nettype none

module pixel_combine (
    input  wire                       rclk,
    input  wire                       rstn,
    input  wire                       pclk_a,
    input  wire                       href_a,
    input  wire cam_pkg::pixel_t      data_a,
    input  wire                       pclk_b,
    input  wire                       href_b,
    input  wire cam_pkg::pixel_t      data_b,
    output logic                      out_valid,
    input  wire                       out_ready,
    output cam_pkg::pixel_pair_t      out_pair,
    output logic                      error
);
    import cam_pkg::*;

    pixel_t      pix_a, pix_b;                         // FIFO heads.
    level_t      level_a, level_b;
    logic        empty_a, empty_b;
    logic        ovf_a, ovf_b;                         // Camera clock domains.
    logic [1:0]  ovf_meta, ovf_sync;
    logic        start, pop;
    logic        first, last;
    logic        can_accept;
    pixel_pair_t in_pair;

    // ========================================
    // Camera FIFOs
    // ========================================
    async_fifo u_fifo_a (
        .wr_clk      (pclk_a),
        .wr_rstn     (rstn),
        .wr_en       (href_a),
        .wr_data     (data_a),
        .wr_full     (),
        .wr_overflow (ovf_a),
        .rd_clk      (rclk),
        .rd_rstn     (rstn),
        .rd_en       (pop),
        .rd_data     (pix_a),
        .rd_empty    (empty_a),
        .rd_level    (level_a)
    );

    async_fifo u_fifo_b (
        .wr_clk      (pclk_b),
        .wr_rstn     (rstn),
        .wr_en       (href_b),
        .wr_data     (data_b),
        .wr_full     (),
        .wr_overflow (ovf_b),
        .rd_clk      (rclk),
        .rd_rstn     (rstn),
        .rd_en       (pop),
        .rd_data     (pix_b),
        .rd_empty    (empty_b),
        .rd_level    (level_b)
    );

    // ========================================
    // Line reader
    // ========================================
    line_read_fsm u_line_read_fsm (
        .rclk       (rclk),
        .rstn       (rstn),
        .level_a    (level_a),
        .level_b    (level_b),
        .empty_a    (empty_a),
        .empty_b    (empty_b),
        .can_accept (can_accept),
        .last       (last),
        .start      (start),
        .pop        (pop)
    );

    pixel_counter u_pixel_counter (
        .rclk  (rclk),
        .rstn  (rstn),
        .start (start),
        .step  (pop),
        .first (first),
        .last  (last)
    );

    assign in_pair = '{pix_a: pix_a, pix_b: pix_b, sol: first, eol: last};

    pair_out_reg u_pair_out_reg (
        .rclk       (rclk),
        .rstn       (rstn),
        .load       (pop),
        .in_pair    (in_pair),
        .can_accept (can_accept),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_pair   (out_pair)
    );

    // Sticky flags, so a plain level crossing is enough.
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            ovf_meta <= '0;
            ovf_sync <= '0;
        end else begin
            ovf_meta <= {ovf_b, ovf_a};
            ovf_sync <= ovf_meta;
        end
    end

    assign error = |ovf_sync;

endmodule : pixel_combine

`default_nettype wire

// File: sim/pixel_combine_chk.sv
`default_nettype none

module pixel_combine_chk (
    input wire                       rclk,
    input wire                       rstn,
    input wire                       out_valid,
    input wire                       out_ready,
    input wire cam_pkg::pixel_pair_t out_pair,
    input wire                       error,
    input wire cam_pkg::rd_state_t   state
);
    import cam_pkg::*;

    int fail_cnt = 0;                                  // Read by the testbench.

    // ========================================
    // Reset state
    // ========================================
    // Also holds on the first edge after release.
    reset_state_a: assert property (@(posedge rclk)
        (!rstn || $rose(rstn)) |-> (!out_valid && !error && state == RD_IDLE))
        else begin
            $error("outputs or reader state not at reset values");
            fail_cnt++;
        end

    // ========================================
    // Output handshake and error flag
    // ========================================
    hold_a: assert property (@(posedge rclk) disable iff (!rstn)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_pair)))
        else begin
            $error("out_pair or out_valid changed while stalled");
            fail_cnt++;
        end

    sticky_a: assert property (@(posedge rclk) disable iff (!rstn)
        error |=> error)
        else begin
            $error("error fell while rstn was high");
            fail_cnt++;
        end

endmodule : pixel_combine_chk

bind pixel_combine pixel_combine_chk u_chk (
    .rclk      (rclk),
    .rstn      (rstn),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_pair  (out_pair),
    .error     (error),
    .state     (u_line_read_fsm.state)
);

`default_nettype wire

// File: sim/tb_pixel_combine.sv
`default_nettype none

module tb_pixel_combine;
    import cam_pkg::*;

    localparam int     NUM_LINES  = 4;
    localparam int     NUM_PAIRS  = NUM_LINES * LINE_LEN;
    localparam int     MAX_CYCLES = 20000;
    localparam pixel_t B_MASK     = 16'hA5A5;

    logic        rclk;
    logic        rstn;
    logic        pclk_a;
    logic        pclk_b;
    logic        href_a;
    logic        href_b;
    pixel_t      data_a;
    pixel_t      data_b;
    logic        out_valid;
    logic        out_ready;
    pixel_pair_t out_pair;
    logic        error;

    int          sent_a;                               // Pixels driven per camera.
    int          sent_b;
    int          pairs_seen;
    int          cycles;
    logic        bp_en;                                // Random out_ready enable.
    logic        ovf_phase;

    pixel_combine DUT (
        .rclk      (rclk),
        .rstn      (rstn),
        .pclk_a    (pclk_a),
        .href_a    (href_a),
        .data_a    (data_a),
        .pclk_b    (pclk_b),
        .href_b    (href_b),
        .data_b    (data_b),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pair  (out_pair),
        .error     (error)
    );

    // ========================================
    // Clocks
    // ========================================
    initial begin
        rclk = 1'b0;
        forever #50 rclk = ~rclk;
    end

    initial begin
        pclk_a = 1'b0;
        forever #65 pclk_a = ~pclk_a;                  // 130 period.
    end

    initial begin
        pclk_b = 1'b0;
        forever #85 pclk_b = ~pclk_b;                  // 170 period.
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    endtask

    // ========================================
    // Camera drivers
    // ========================================
    task automatic send_a(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge pclk_a);
            #10;
            href_a = 1'b1;
            data_a = pixel_t'(sent_a);
            sent_a++;
        end
        @(posedge pclk_a);                             // Last pixel written here.
        #10;
        href_a = 1'b0;
    endtask

    task automatic send_b(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge pclk_b);
            #10;
            href_b = 1'b1;
            data_b = pixel_t'(sent_b) ^ B_MASK;
            sent_b++;
        end
        @(posedge pclk_b);
        #10;
        href_b = 1'b0;
    endtask

    task automatic stream_a(input int lines);
        repeat (lines) begin
            repeat ($urandom_range(0, 8)) @(posedge pclk_a);
            send_a(LINE_LEN);
        end
    endtask

    task automatic stream_b(input int lines);
        repeat (lines) begin
            repeat ($urandom_range(0, 8)) @(posedge pclk_b);
            send_b(LINE_LEN);
        end
    endtask

    // About 30 percent low while back-pressure is on.
    always @(posedge rclk) begin
        #10;
        out_ready = bp_en ? ($urandom_range(0, 9) >= 3) : 1'b1;
    end

    // ========================================
    // Scoreboard
    // ========================================
    task automatic check_pair(input int idx);
        pixel_t exp_a;
        pixel_t exp_b;
        exp_a = pixel_t'(idx);
        exp_b = exp_a ^ B_MASK;
        assert (idx < NUM_PAIRS) else fail_run("pair transferred beyond the streamed pixels");
        assert (out_pair.pix_a == exp_a) else mismatch("out_pair.pix_a", out_pair.pix_a, exp_a);
        assert (out_pair.pix_b == exp_b) else mismatch("out_pair.pix_b", out_pair.pix_b, exp_b);
        assert (out_pair.sol == (idx % LINE_LEN == 0))
            else mismatch("out_pair.sol", out_pair.sol, (idx % LINE_LEN == 0));
        assert (out_pair.eol == (idx % LINE_LEN == LINE_LEN - 1))
            else mismatch("out_pair.eol", out_pair.eol, (idx % LINE_LEN == LINE_LEN - 1));
    endtask

    // Sampled mid-cycle, values hold until the next rising edge.
    always @(negedge rclk) begin
        if (DUT.u_chk.fail_cnt != 0) begin
            fail_run("a bound assertion in pixel_combine_chk failed");
        end
        if (rstn) begin
            if (sent_b == 0) begin
                assert (out_valid == 1'b0) else mismatch("out_valid", out_valid, 1'b0);
            end
            if (!ovf_phase) begin
                assert (error == 1'b0) else mismatch("error", error, 1'b0);
            end
            if (out_valid && out_ready) begin
                check_pair(pairs_seen);
                pairs_seen++;
            end
        end
    end

    always @(posedge rclk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            fail_run($sformatf("timeout after %0d rclk cycles", cycles));
        end
    end

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        void'($urandom(32'hb175_f36b));
        rstn       = 1'b0;
        href_a     = 1'b0;
        href_b     = 1'b0;
        data_a     = '0;
        data_b     = '0;
        out_ready  = 1'b1;
        bp_en      = 1'b0;
        ovf_phase  = 1'b0;
        sent_a     = 0;
        sent_b     = 0;
        pairs_seen = 0;
        cycles     = 0;
        repeat (16) @(posedge rclk);
        #10;
        rstn = 1'b1;

        // Camera A alone, nothing may come out.
        send_a(LINE_LEN);
        repeat (20) @(posedge rclk);
        send_b(LINE_LEN);
        while (pairs_seen < LINE_LEN) @(posedge rclk);

        // Both cameras with random gaps, downstream stalls.
        bp_en = 1'b1;
        fork
            stream_a(NUM_LINES - 1);
            stream_b(NUM_LINES - 1);
        join
        while (pairs_seen < NUM_PAIRS) @(posedge rclk);
        bp_en = 1'b0;

        // Overrun FIFO A with camera B silent.
        ovf_phase = 1'b1;
        send_a(FIFO_DEPTH + 8);
        for (int i = 0; i < 10 && !error; i++) @(negedge rclk);
        assert (error == 1'b1) else mismatch("error", error, 1'b1);
        repeat (20) @(posedge rclk);

        if (DUT.u_chk.fail_cnt != 0) begin
            fail_run("a bound assertion in pixel_combine_chk failed");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule : tb_pixel_combine

`default_nettype wire

// File: files.f
hdl/cam_pkg.sv
hdl/async_fifo.sv
hdl/pixel_counter.sv
hdl/line_read_fsm.sv
hdl/pair_out_reg.sv
hdl/pixel_combine.sv
sim/pixel_combine_chk.sv
sim/tb_pixel_combine.sv
